// File: all.f
hw/mips_pkg.sv
hw/reg_file.sv
hw/decode_stage.sv
hw/add_sub_logic.sv
hw/execute_stage.sv
hw/int_pipe_top.sv
bench/int_pipe_tb.sv

// File: bench/int_pipe_tb.sv
`timescale 1ns/100ps
`default_nettype none

module int_pipe_tb;

    typedef struct packed {
        logic        wb_valid;
        logic [4:0]  wb_reg;
        logic [31:0] wb_data;
        logic        mem_valid;
        logic        mem_write;
        logic [31:0] mem_addr;
        logic [31:0] mem_wdata;
        logic        br_valid;
        logic        br_taken;
        logic [31:0] br_target;
    } exp_t;

    logic        clk;
    logic        rst_n;
    logic        instr_valid;
    logic [31:0] instr;
    logic [31:0] instr_pc;
    logic        wb_valid;
    logic [4:0]  wb_reg;
    logic [31:0] wb_data;
    logic        mem_valid;
    logic        mem_write;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic        br_valid;
    logic        br_taken;
    logic [31:0] br_target;

    logic [31:0] model_regs [32];
    logic [31:0] pc;
    exp_t        next_exp;
    exp_t        exp_out;
    exp_t        exp_q [$];
    int          id_q [$];
    int          next_test;
    int          exp_test;
    int          test_id;
    int          seed;
    int          cycle_count;
    string       test_names [8];

    int_pipe_top dut0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_pc    (instr_pc),
        .wb_valid    (wb_valid),
        .wb_reg      (wb_reg),
        .wb_data     (wb_data),
        .mem_valid   (mem_valid),
        .mem_write   (mem_write),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .br_valid    (br_valid),
        .br_taken    (br_taken),
        .br_target   (br_target)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_mismatch(input string field, input logic [31:0] expected,
                                   input logic [31:0] actual);
        abort_run($sformatf("Fail %s: %s expected %h actual %h",
                            test_names[exp_test], field, expected, actual));
    endtask

    function automatic logic [31:0] i_word(input logic [5:0] op, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] r_word(input logic [5:0] fn, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [4:0] rd);
        return {6'd0, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [5:0] imm_opcode(input int k);
        case (k % 4)
            0:       return mips_pkg::addiu;
            1:       return mips_pkg::andi;
            2:       return mips_pkg::ori;
            default: return mips_pkg::xori;
        endcase
    endfunction

    function automatic logic [5:0] r_funct(input int k);
        case (k % 7)
            0:       return mips_pkg::addu;
            1:       return mips_pkg::subu;
            2:       return mips_pkg::and_f;
            3:       return mips_pkg::or_f;
            4:       return mips_pkg::xor_f;
            5:       return mips_pkg::slt;
            default: return mips_pkg::sltu;
        endcase
    endfunction

    function automatic logic [5:0] mem_opcode(input int k);
        case (k % 8)
            0:       return mips_pkg::lb;
            1:       return mips_pkg::sb;
            2:       return mips_pkg::lh;
            3:       return mips_pkg::sh;
            4:       return mips_pkg::lw;
            5:       return mips_pkg::sw;
            6:       return mips_pkg::lbu;
            default: return mips_pkg::lhu;
        endcase
    endfunction

    // Updates the ISA model and drives the word on the next rising edge.
    task automatic issue(input logic [31:0] word);
        exp_t        e;
        logic [5:0]  op;
        logic [5:0]  fn;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] simm;
        logic [31:0] zimm;
        op   = word[31:26];
        fn   = word[5:0];
        rs   = word[25:21];
        rt   = word[20:16];
        a    = model_regs[rs];
        b    = model_regs[rt];
        simm = {{16{word[15]}}, word[15:0]};
        zimm = {16'd0, word[15:0]};
        e    = '0;
        case (op)
            mips_pkg::special: begin
                e.wb_valid = 1'b1;
                e.wb_reg   = word[15:11];
                case (fn)
                    mips_pkg::addu:  e.wb_data = a + b;
                    mips_pkg::subu:  e.wb_data = a - b;
                    mips_pkg::and_f: e.wb_data = a & b;
                    mips_pkg::or_f:  e.wb_data = a | b;
                    mips_pkg::xor_f: e.wb_data = a ^ b;
                    mips_pkg::slt:   e.wb_data = {31'd0, $signed(a) < $signed(b)};
                    mips_pkg::sltu:  e.wb_data = {31'd0, a < b};
                    default:         e = '0; // Funct not supported.
                endcase
            end
            mips_pkg::addiu, mips_pkg::slti, mips_pkg::sltiu,
            mips_pkg::andi, mips_pkg::ori, mips_pkg::xori: begin
                e.wb_valid = 1'b1;
                e.wb_reg   = rt;
                case (op)
                    mips_pkg::addiu: e.wb_data = a + simm;
                    mips_pkg::slti:  e.wb_data = {31'd0, $signed(a) < $signed(simm)};
                    mips_pkg::sltiu: e.wb_data = {31'd0, a < simm};
                    mips_pkg::andi:  e.wb_data = a & zimm;
                    mips_pkg::ori:   e.wb_data = a | zimm;
                    default:         e.wb_data = a ^ zimm;
                endcase
            end
            mips_pkg::lb, mips_pkg::lh, mips_pkg::lw, mips_pkg::lbu, mips_pkg::lhu,
            mips_pkg::sb, mips_pkg::sh, mips_pkg::sw: begin
                e.mem_valid = 1'b1;
                e.mem_write = (op == mips_pkg::sb) || (op == mips_pkg::sh) ||
                              (op == mips_pkg::sw);
                e.mem_addr  = a + simm;
                e.mem_wdata = b;
            end
            mips_pkg::beq, mips_pkg::bne, mips_pkg::blez, mips_pkg::bgtz: begin
                e.br_valid  = 1'b1;
                e.br_target = pc + 32'd4 + (simm << 2);
                case (op)
                    mips_pkg::beq:  e.br_taken = (a == b);
                    mips_pkg::bne:  e.br_taken = (a != b);
                    mips_pkg::blez: e.br_taken = ($signed(a) <= 0);
                    default:        e.br_taken = ($signed(a) > 0);
                endcase
            end
            default: e = '0;
        endcase
        if (e.wb_valid && (e.wb_reg != 5'd0)) begin
            model_regs[e.wb_reg] = e.wb_data;
        end
        @(posedge clk);
        instr_valid <= 1'b1;
        instr       <= word;
        instr_pc    <= pc;
        next_exp    <= e;
        next_test   <= test_id;
        pc = pc + 32'd4;
    endtask

    task automatic idle_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            instr_valid <= 1'b0;
            next_exp    <= '0;
            next_test   <= test_id;
        end
    endtask

    task automatic init_inputs();
        rst_n       <= 1'b0;
        instr_valid <= 1'b0;
        instr       <= '0;
        instr_pc    <= '0;
        next_exp    <= '0;
        next_test   <= 0;
    endtask

    task automatic apply_reset();
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
    endtask

    // Expected outputs trail the driven instruction by two edges.
    always @(posedge clk) begin
        if (!rst_n) begin
            exp_q.delete();
            id_q.delete();
            exp_q.push_back(next_exp);
            id_q.push_back(next_test);
            exp_out  <= '0;
            exp_test <= 0;
        end else begin
            exp_q.push_back(next_exp);
            id_q.push_back(next_test);
            exp_out  <= exp_q.pop_front();
            exp_test <= id_q.pop_front();
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == 2000) begin // Far longer than the whole sequence.
            abort_run("Timeout: the test sequence did not finish within 2000 cycles.");
        end
    end

    // Outputs are compared mid cycle.
    check_wb_valid: assert property (@(negedge clk) disable iff (!rst_n)
        wb_valid == exp_out.wb_valid)
        else report_mismatch("wb_valid", {31'd0, exp_out.wb_valid}, {31'd0, wb_valid});
    check_wb_reg: assert property (@(negedge clk) disable iff (!rst_n)
        !exp_out.wb_valid || (wb_reg == exp_out.wb_reg))
        else report_mismatch("wb_reg", {27'd0, exp_out.wb_reg}, {27'd0, wb_reg});
    check_wb_data: assert property (@(negedge clk) disable iff (!rst_n)
        !exp_out.wb_valid || (wb_data == exp_out.wb_data))
        else report_mismatch("wb_data", exp_out.wb_data, wb_data);
    check_mem_valid: assert property (@(negedge clk) disable iff (!rst_n)
        mem_valid == exp_out.mem_valid)
        else report_mismatch("mem_valid", {31'd0, exp_out.mem_valid}, {31'd0, mem_valid});
    check_mem_write: assert property (@(negedge clk) disable iff (!rst_n)
        !exp_out.mem_valid || (mem_write == exp_out.mem_write))
        else report_mismatch("mem_write", {31'd0, exp_out.mem_write}, {31'd0, mem_write});
    check_mem_addr: assert property (@(negedge clk) disable iff (!rst_n)
        !exp_out.mem_valid || (mem_addr == exp_out.mem_addr))
        else report_mismatch("mem_addr", exp_out.mem_addr, mem_addr);
    check_mem_wdata: assert property (@(negedge clk) disable iff (!rst_n)
        !(exp_out.mem_valid && exp_out.mem_write) || (mem_wdata == exp_out.mem_wdata))
        else report_mismatch("mem_wdata", exp_out.mem_wdata, mem_wdata);
    check_br_valid: assert property (@(negedge clk) disable iff (!rst_n)
        br_valid == exp_out.br_valid)
        else report_mismatch("br_valid", {31'd0, exp_out.br_valid}, {31'd0, br_valid});
    check_br_taken: assert property (@(negedge clk) disable iff (!rst_n)
        !exp_out.br_valid || (br_taken == exp_out.br_taken))
        else report_mismatch("br_taken", {31'd0, exp_out.br_taken}, {31'd0, br_taken});
    check_br_target: assert property (@(negedge clk) disable iff (!rst_n)
        !exp_out.br_valid || (br_target == exp_out.br_target))
        else report_mismatch("br_target", exp_out.br_target, br_target);

    initial begin
        logic [31:0] rnd;
        logic [4:0]  src;
        logic [4:0]  dst;
        logic [4:0]  prev;
        logic [4:0]  pprev;
        test_names[0] = "reset";
        test_names[1] = "imm_from_zero";
        test_names[2] = "imm_from_regs";
        test_names[3] = "forward_chain";
        test_names[4] = "compare";
        test_names[5] = "load_store";
        test_names[6] = "branch";
        test_names[7] = "unknown_opcode";
        seed    = 14127;
        pc      = 32'h0000_1000;
        test_id = 0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        init_inputs();
        apply_reset();
        idle_cycles(3); // Strobes must stay low here.

        test_id = 1;
        for (int i = 1; i < 9; i++) begin
            rnd = $random(seed);
            issue(i_word(imm_opcode(i), 5'd0, i[4:0], rnd[15:0]));
        end
        test_id = 2;
        for (int i = 0; i < 12; i++) begin
            rnd = $random(seed);
            src = 5'd1 + {2'b00, rnd[18:16]};
            dst = 5'd9 + {2'b00, rnd[21:19]};
            issue(i_word(imm_opcode(i), src, dst, rnd[15:0]));
        end
        idle_cycles(2);

        // Dependent chains at distance 1, 2 and 3 padded by independent fillers.
        test_id = 3;
        for (int d = 1; d < 4; d++) begin
            rnd = $random(seed);
            issue(i_word(mips_pkg::addiu, 5'd0, 5'd9, rnd[15:0])); // Fresh chain inputs.
            issue(i_word(mips_pkg::addiu, 5'd0, 5'd10, rnd[31:16]));
            prev  = 5'd9;
            pprev = 5'd10;
            for (int k = 0; k < 7; k++) begin
                dst = 5'd17 + k[4:0];
                issue(r_word(r_funct(k), prev, pprev, dst));
                for (int f = 1; f < d; f++) begin
                    issue(r_word(mips_pkg::or_f, 5'd2, 5'd3, 5'd26 + f[4:0]));
                end
                pprev = prev;
                prev  = dst;
            end
        end

        test_id = 4;
        issue(i_word(mips_pkg::addiu, 5'd0, 5'd20, 16'hffff)); // Minus one.
        issue(i_word(mips_pkg::addiu, 5'd0, 5'd21, 16'h0001));
        issue(i_word(mips_pkg::ori, 5'd0, 5'd22, 16'h8000));
        issue(r_word(mips_pkg::slt, 5'd20, 5'd21, 5'd23));
        issue(r_word(mips_pkg::sltu, 5'd20, 5'd21, 5'd24));
        issue(r_word(mips_pkg::slt, 5'd21, 5'd20, 5'd23));
        issue(r_word(mips_pkg::sltu, 5'd21, 5'd20, 5'd24));
        issue(i_word(mips_pkg::slti, 5'd20, 5'd25, 16'h0001));
        issue(i_word(mips_pkg::sltiu, 5'd20, 5'd25, 16'h0001));
        issue(i_word(mips_pkg::slti, 5'd22, 5'd25, 16'h8000));
        issue(i_word(mips_pkg::sltiu, 5'd22, 5'd25, 16'h8000));
        issue(i_word(mips_pkg::addiu, 5'd21, 5'd0, 16'h0005)); // Dropped write to r0.
        issue(r_word(mips_pkg::addu, 5'd0, 5'd0, 5'd26));
        issue(r_word(mips_pkg::or_f, 5'd0, 5'd21, 5'd26));

        test_id = 5;
        for (int i = 0; i < 16; i++) begin
            rnd = $random(seed);
            src = 5'd1 + {2'b00, rnd[18:16]};
            dst = 5'd9 + {2'b00, rnd[21:19]};
            issue(i_word(mem_opcode(i), src, dst, rnd[15:0]));
        end
        issue(i_word(mips_pkg::addiu, 5'd0, 5'd27, 16'h1234));
        issue(i_word(mips_pkg::sw, 5'd27, 5'd27, 16'hfffc)); // Base and data forwarded.

        // Negative, zero and positive rs.
        test_id = 6;
        for (int s = 0; s < 3; s++) begin
            rnd = $random(seed);
            src = (s == 0) ? 5'd20 : ((s == 1) ? 5'd0 : 5'd21);
            issue(i_word(mips_pkg::blez, src, 5'd0, rnd[15:0]));
            issue(i_word(mips_pkg::bgtz, src, 5'd0, rnd[31:16]));
            issue(i_word(mips_pkg::beq, src, src, rnd[15:0]));
            issue(i_word(mips_pkg::bne, src, src, rnd[31:16]));
            issue(i_word(mips_pkg::beq, src, 5'd21, rnd[31:16]));
            issue(i_word(mips_pkg::bne, src, 5'd21, rnd[15:0]));
        end

        test_id = 7;
        issue(32'hfc00_0000);
        issue(r_word(6'h00, 5'd1, 5'd2, 5'd3)); // Shift funct is not kept.
        issue(i_word(6'h02, 5'd0, 5'd0, 16'h0010));
        idle_cycles(4);
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: hw/add_sub_logic.sv
`timescale 1ns/100ps
`default_nettype none

module add_sub_logic (
    input  logic [5:0]                  opcode,
    input  logic [5:0]                  funct,
    input  logic [mips_pkg::data_w-1:0] op1,
    input  logic [mips_pkg::data_w-1:0] op2,
    output logic [mips_pkg::data_w-1:0] add_sub_out,
    output logic [3:0]                  branch_conditions
);

    logic [mips_pkg::data_w-1:0] add_res;
    logic [mips_pkg::data_w-1:0] sub_res;
    logic [mips_pkg::data_w-1:0] and_res;
    logic [mips_pkg::data_w-1:0] or_res;
    logic [mips_pkg::data_w-1:0] xor_res;
    logic                        lt_signed;
    logic                        lt_unsigned;

    assign add_res     = op1 + op2;
    assign sub_res     = op1 - op2;
    assign and_res     = op1 & op2;
    assign or_res      = op1 | op2;
    assign xor_res     = op1 ^ op2;
    assign lt_signed   = $signed(op1) < $signed(op2);
    assign lt_unsigned = op1 < op2;

    always_comb begin
        add_sub_out = '0; // Unlisted codes give zero.
        if (opcode == mips_pkg::special) begin
            case (funct)
                mips_pkg::addu:  add_sub_out = add_res;
                mips_pkg::subu:  add_sub_out = sub_res;
                mips_pkg::and_f: add_sub_out = and_res;
                mips_pkg::or_f:  add_sub_out = or_res;
                mips_pkg::xor_f: add_sub_out = xor_res;
                mips_pkg::slt:   add_sub_out[0] = lt_signed;
                mips_pkg::sltu:  add_sub_out[0] = lt_unsigned;
                default:         add_sub_out = '0;
            endcase
        end else begin
            case (opcode)
                // Loads and stores take the sum as their address.
                mips_pkg::addiu,
                mips_pkg::lb, mips_pkg::lh, mips_pkg::lw, mips_pkg::lbu, mips_pkg::lhu,
                mips_pkg::sb, mips_pkg::sh, mips_pkg::sw: add_sub_out = add_res;
                mips_pkg::andi:  add_sub_out = and_res;
                mips_pkg::ori:   add_sub_out = or_res;
                mips_pkg::xori:  add_sub_out = xor_res;
                mips_pkg::slti:  add_sub_out[0] = lt_signed;
                mips_pkg::sltiu: add_sub_out[0] = lt_unsigned;
                default:         add_sub_out = '0;
            endcase
        end
    end

    // Sign of op1 is one-hot in the low three bits.
    always_comb begin
        branch_conditions = '0;
        if ($signed(op1) < 0) begin
            branch_conditions[mips_pkg::cond_neg] = 1'b1;
        end else if (op1 == '0) begin
            branch_conditions[mips_pkg::cond_zero] = 1'b1;
        end else begin
            branch_conditions[mips_pkg::cond_pos] = 1'b1;
        end
        branch_conditions[mips_pkg::cond_eq] = (op1 == op2);
    end

endmodule

`default_nettype wire

// File: hw/decode_stage.sv
`timescale 1ns/100ps
`default_nettype none

module decode_stage (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            instr_valid,
    input  logic [31:0]                     instr,
    input  logic [31:0]                     instr_pc,
    output logic                            ex_valid,
    output logic [5:0]                      ex_opcode,
    output logic [5:0]                      ex_funct,
    output logic [mips_pkg::reg_addr_w-1:0] ex_rs,
    output logic [mips_pkg::reg_addr_w-1:0] ex_rt,
    output logic [mips_pkg::data_w-1:0]     ex_imm,
    output logic                            ex_use_imm,
    output logic [mips_pkg::reg_addr_w-1:0] ex_dest,
    output logic                            ex_wr_en,
    output mips_pkg::br_kind_e              ex_br_kind,
    output mips_pkg::mem_kind_e             ex_mem_kind,
    output logic [31:0]                     ex_pc
);

    logic [5:0]                      opcode;
    logic [5:0]                      funct;
    logic [mips_pkg::reg_addr_w-1:0] rs;
    logic [mips_pkg::reg_addr_w-1:0] rt;
    logic [mips_pkg::reg_addr_w-1:0] rd;
    logic [15:0]                     imm16;
    logic [mips_pkg::data_w-1:0]     imm_ext;
    logic                            known;
    logic                            use_imm;
    logic                            zero_ext;
    logic                            wr_en;
    logic [mips_pkg::reg_addr_w-1:0] dest;
    mips_pkg::br_kind_e              br_kind;
    mips_pkg::mem_kind_e             mem_kind;

    assign opcode = instr[31:26];
    assign rs     = instr[25:21];
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];
    assign funct  = instr[5:0];
    assign imm16  = instr[15:0];

    // Logic immediates are zero extended, the rest sign extended.
    assign imm_ext = zero_ext ? {16'd0, imm16} : {{16{imm16[15]}}, imm16};

    always_comb begin
        known    = 1'b1;
        use_imm  = 1'b1;
        zero_ext = 1'b0;
        wr_en    = 1'b0;
        dest     = '0;
        br_kind  = mips_pkg::br_none;
        mem_kind = mips_pkg::mem_none;
        case (opcode)
            mips_pkg::special: begin
                use_imm = 1'b0;
                wr_en   = 1'b1;
                dest    = rd;
                case (funct)
                    mips_pkg::addu, mips_pkg::subu, mips_pkg::and_f, mips_pkg::or_f,
                    mips_pkg::xor_f, mips_pkg::slt, mips_pkg::sltu: known = 1'b1;
                    default: known = 1'b0;
                endcase
            end
            mips_pkg::addiu, mips_pkg::slti, mips_pkg::sltiu: begin
                wr_en = 1'b1;
                dest  = rt;
            end
            mips_pkg::andi, mips_pkg::ori, mips_pkg::xori: begin
                wr_en    = 1'b1;
                dest     = rt;
                zero_ext = 1'b1;
            end
            mips_pkg::lb, mips_pkg::lh, mips_pkg::lw, mips_pkg::lbu, mips_pkg::lhu:
                mem_kind = mips_pkg::mem_load; // Address only, no write back.
            mips_pkg::sb, mips_pkg::sh, mips_pkg::sw:
                mem_kind = mips_pkg::mem_store;
            mips_pkg::beq: begin
                use_imm = 1'b0; // Compare rs against rt.
                br_kind = mips_pkg::br_eq;
            end
            mips_pkg::bne: begin
                use_imm = 1'b0;
                br_kind = mips_pkg::br_ne;
            end
            mips_pkg::blez: br_kind = mips_pkg::br_lez;
            mips_pkg::bgtz: br_kind = mips_pkg::br_gtz;
            default: known = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= instr_valid && known;
        end
    end

    // Fields only matter while ex_valid is high.
    always_ff @(posedge clk) begin
        if (instr_valid) begin
            ex_opcode   <= opcode;
            ex_funct    <= funct;
            ex_rs       <= rs;
            ex_rt       <= rt;
            ex_imm      <= imm_ext;
            ex_use_imm  <= use_imm;
            ex_dest     <= dest;
            ex_wr_en    <= wr_en;
            ex_br_kind  <= br_kind;
            ex_mem_kind <= mem_kind;
            ex_pc       <= instr_pc;
        end
    end

endmodule

`default_nettype wire

// File: hw/execute_stage.sv
`timescale 1ns/100ps
`default_nettype none

module execute_stage (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            ex_valid,
    input  logic [5:0]                      ex_opcode,
    input  logic [5:0]                      ex_funct,
    input  logic [mips_pkg::reg_addr_w-1:0] ex_rs,
    input  logic [mips_pkg::reg_addr_w-1:0] ex_rt,
    input  logic [mips_pkg::data_w-1:0]     ex_imm,
    input  logic                            ex_use_imm,
    input  logic [mips_pkg::reg_addr_w-1:0] ex_dest,
    input  logic                            ex_wr_en,
    input  mips_pkg::br_kind_e              ex_br_kind,
    input  mips_pkg::mem_kind_e             ex_mem_kind,
    input  logic [31:0]                     ex_pc,
    input  logic [mips_pkg::data_w-1:0]     rf_data_a,
    input  logic [mips_pkg::data_w-1:0]     rf_data_b,
    output logic [mips_pkg::reg_addr_w-1:0] rf_addr_a,
    output logic [mips_pkg::reg_addr_w-1:0] rf_addr_b,
    output logic                            wb_valid,
    output logic [mips_pkg::reg_addr_w-1:0] wb_reg,
    output logic [mips_pkg::data_w-1:0]     wb_data,
    output logic                            mem_valid,
    output logic                            mem_write,
    output logic [31:0]                     mem_addr,
    output logic [mips_pkg::data_w-1:0]     mem_wdata,
    output logic                            br_valid,
    output logic                            br_taken,
    output logic [31:0]                     br_target
);

    logic [mips_pkg::data_w-1:0] rs_val;
    logic [mips_pkg::data_w-1:0] rt_val;
    logic [mips_pkg::data_w-1:0] op2;
    logic [mips_pkg::data_w-1:0] alu_out;
    logic [3:0]                  br_cond;
    logic                        taken;
    logic                        do_wb;
    logic                        do_mem;
    logic                        do_br;

    assign rf_addr_a = ex_rs;
    assign rf_addr_b = ex_rt;

    // Distance-1 bypass from our own output register.
    assign rs_val = (wb_valid && (wb_reg == ex_rs) && (wb_reg != '0)) ? wb_data : rf_data_a;
    assign rt_val = (wb_valid && (wb_reg == ex_rt) && (wb_reg != '0)) ? wb_data : rf_data_b;
    assign op2    = ex_use_imm ? ex_imm : rt_val;

    add_sub_logic u_alu (
        .opcode            (ex_opcode),
        .funct             (ex_funct),
        .op1               (rs_val),
        .op2               (op2),
        .add_sub_out       (alu_out),
        .branch_conditions (br_cond)
    );

    always_comb begin
        case (ex_br_kind)
            mips_pkg::br_eq:  taken = br_cond[mips_pkg::cond_eq];
            mips_pkg::br_ne:  taken = !br_cond[mips_pkg::cond_eq];
            mips_pkg::br_lez: taken = br_cond[mips_pkg::cond_neg] | br_cond[mips_pkg::cond_zero];
            mips_pkg::br_gtz: taken = br_cond[mips_pkg::cond_pos];
            default:          taken = 1'b0;
        endcase
    end

    assign do_wb  = ex_valid && ex_wr_en;
    assign do_mem = ex_valid && (ex_mem_kind != mips_pkg::mem_none);
    assign do_br  = ex_valid && (ex_br_kind != mips_pkg::br_none);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid  <= 1'b0;
            mem_valid <= 1'b0;
            br_valid  <= 1'b0;
        end else begin
            wb_valid  <= do_wb;
            mem_valid <= do_mem;
            br_valid  <= do_br;
        end
    end

    always_ff @(posedge clk) begin
        if (do_wb) begin
            wb_reg  <= ex_dest;
            wb_data <= alu_out;
        end
        if (do_mem) begin
            mem_write <= (ex_mem_kind == mips_pkg::mem_store);
            mem_addr  <= alu_out;
            mem_wdata <= rt_val;
        end
        if (do_br) begin
            br_taken  <= taken;
            br_target <= ex_pc + 32'd4 + {ex_imm[29:0], 2'b00}; // Word offset.
        end
    end

endmodule

`default_nettype wire

// File: hw/int_pipe_top.sv
`timescale 1ns/100ps
`default_nettype none

module int_pipe_top (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        instr_valid,
    input  logic [31:0] instr,
    input  logic [31:0] instr_pc,
    output logic        wb_valid,
    output logic [4:0]  wb_reg,
    output logic [31:0] wb_data,
    output logic        mem_valid,
    output logic        mem_write,
    output logic [31:0] mem_addr,
    output logic [31:0] mem_wdata,
    output logic        br_valid,
    output logic        br_taken,
    output logic [31:0] br_target
);

    logic                ex_valid;
    logic [5:0]          ex_opcode;
    logic [5:0]          ex_funct;
    logic [4:0]          ex_rs;
    logic [4:0]          ex_rt;
    logic [31:0]         ex_imm;
    logic                ex_use_imm;
    logic [4:0]          ex_dest;
    logic                ex_wr_en;
    mips_pkg::br_kind_e  ex_br_kind;
    mips_pkg::mem_kind_e ex_mem_kind;
    logic [31:0]         ex_pc;
    logic [4:0]          rf_addr_a;
    logic [4:0]          rf_addr_b;
    logic [31:0]         rf_data_a;
    logic [31:0]         rf_data_b;

    decode_stage u_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_pc    (instr_pc),
        .ex_valid    (ex_valid),
        .ex_opcode   (ex_opcode),
        .ex_funct    (ex_funct),
        .ex_rs       (ex_rs),
        .ex_rt       (ex_rt),
        .ex_imm      (ex_imm),
        .ex_use_imm  (ex_use_imm),
        .ex_dest     (ex_dest),
        .ex_wr_en    (ex_wr_en),
        .ex_br_kind  (ex_br_kind),
        .ex_mem_kind (ex_mem_kind),
        .ex_pc       (ex_pc)
    );

    execute_stage u_execute (
        .clk         (clk),
        .rst_n       (rst_n),
        .ex_valid    (ex_valid),
        .ex_opcode   (ex_opcode),
        .ex_funct    (ex_funct),
        .ex_rs       (ex_rs),
        .ex_rt       (ex_rt),
        .ex_imm      (ex_imm),
        .ex_use_imm  (ex_use_imm),
        .ex_dest     (ex_dest),
        .ex_wr_en    (ex_wr_en),
        .ex_br_kind  (ex_br_kind),
        .ex_mem_kind (ex_mem_kind),
        .ex_pc       (ex_pc),
        .rf_data_a   (rf_data_a),
        .rf_data_b   (rf_data_b),
        .rf_addr_a   (rf_addr_a),
        .rf_addr_b   (rf_addr_b),
        .wb_valid    (wb_valid),
        .wb_reg      (wb_reg),
        .wb_data     (wb_data),
        .mem_valid   (mem_valid),
        .mem_write   (mem_write),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .br_valid    (br_valid),
        .br_taken    (br_taken),
        .br_target   (br_target)
    );

    // Write port is fed straight from the execute output register.
    reg_file u_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_en     (wb_valid),
        .wr_addr   (wb_reg),
        .wr_data   (wb_data),
        .rd_addr_a (rf_addr_a),
        .rd_addr_b (rf_addr_b),
        .rd_data_a (rf_data_a),
        .rd_data_b (rf_data_b)
    );

endmodule

`default_nettype wire

// File: hw/mips_pkg.sv
`default_nettype none

package mips_pkg;

    localparam int data_w     = 32;
    localparam int reg_addr_w = 5;
    localparam int num_regs   = 32;

    // Bit positions inside branch_conditions.
    localparam int cond_neg  = 0;
    localparam int cond_zero = 1;
    localparam int cond_pos  = 2;
    localparam int cond_eq   = 3;

    typedef enum logic [5:0] {
        special = 6'b000000, // R-type, see funct.
        beq     = 6'b000100,
        bne     = 6'b000101,
        blez    = 6'b000110,
        bgtz    = 6'b000111,
        addiu   = 6'b001001,
        slti    = 6'b001010,
        sltiu   = 6'b001011,
        andi    = 6'b001100,
        ori     = 6'b001101,
        xori    = 6'b001110,
        lb      = 6'b100000,
        lh      = 6'b100001,
        lw      = 6'b100011,
        lbu     = 6'b100100,
        lhu     = 6'b100101,
        sb      = 6'b101000,
        sh      = 6'b101001,
        sw      = 6'b101011
    } opcode_e;

    typedef enum logic [5:0] {
        addu  = 6'b100001,
        subu  = 6'b100011,
        and_f = 6'b100100,
        or_f  = 6'b100101,
        xor_f = 6'b100110,
        slt   = 6'b101010,
        sltu  = 6'b101011
    } funct_e;

    typedef enum logic [2:0] {br_none, br_eq, br_ne, br_lez, br_gtz} br_kind_e;

    typedef enum logic [1:0] {mem_none, mem_load, mem_store} mem_kind_e;

endpackage

`default_nettype wire

// File: hw/reg_file.sv
`timescale 1ns/100ps
`default_nettype none

module reg_file (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            wr_en,
    input  logic [mips_pkg::reg_addr_w-1:0] wr_addr,
    input  logic [mips_pkg::data_w-1:0]     wr_data,
    input  logic [mips_pkg::reg_addr_w-1:0] rd_addr_a,
    input  logic [mips_pkg::reg_addr_w-1:0] rd_addr_b,
    output logic [mips_pkg::data_w-1:0]     rd_data_a,
    output logic [mips_pkg::data_w-1:0]     rd_data_b
);

    logic [mips_pkg::data_w-1:0] regs [mips_pkg::num_regs];

    // Register 0 is cleared by reset and never written after.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < mips_pkg::num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_addr != '0)) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Asynchronous read ports.
    assign rd_data_a = regs[rd_addr_a];
    assign rd_data_b = regs[rd_addr_b];

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module int_pipe_tb -o int_pipe_sim

./obj_dir/int_pipe_sim | tee sim.log

if grep -q "TEST FAILED" sim.log; then
    echo "Simulation reported a failure."
    exit 1
fi
if ! grep -q "TEST OK" sim.log; then
    echo "Simulation ended without a result."
    exit 1
fi
echo "Simulation passed."
